//--- Makefile
# Verilator build for the NIC receive path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_nic_rx
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
nic_pkg.sv
rx_mac_interface.sv
rx_frame_buffer.sv
rx_host_reader.sv
nic_rx_top.sv
tb_clock_gen.sv
tb_nic_rx.sv

//--- nic_pkg.sv
// Shared definitions for the 10G NIC receive path
// Buffer geometry, MAC word widths and the types that cross
// between the MAC side, the frame buffer and the host reader

package nic_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int BUF_AW    = 10;                  // Buffer address bits
    localparam int BUF_DEPTH = 1 << BUF_AW;         // 1024 word slots
    localparam int DATA_W    = 64;                  // XGMAC data width
    localparam int KEEP_W    = DATA_W / 8;          // One valid bit per byte
    localparam int DROP_W    = 16;                  // Dropped frame counter

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------
    // One stored word, 73 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;                    // MAC payload
        logic [KEEP_W-1:0] keep;                    // Low bytes valid, contiguous
        logic              last;                    // Final word of a good frame
    } rx_word_t;

    typedef logic [BUF_AW-1:0] buf_addr_t;          // RAM slot index

    // Extra MSB is the wrap bit so full and empty differ
    typedef logic [BUF_AW:0]   buf_ptr_t;

    typedef logic [DROP_W-1:0] drop_cnt_t;          // Wraps silently

endpackage

//--- nic_rx_top.sv
// NIC receive path top level
// Connects the MAC receive interface, the frame buffer and the
// host reader, all in the 156.25 MHz domain

`timescale 1ns/10ps

module nic_rx_top (
    input  logic                         clk156_25,
    input  logic                         rst_n,
    // MAC rx
    input  logic [nic_pkg::DATA_W-1:0]   rx_data,
    input  logic [nic_pkg::KEEP_W-1:0]   rx_data_valid,
    input  logic                         rx_good_frame,
    input  logic                         rx_bad_frame,
    // Host
    input  logic                         host_rd_en,
    output logic                         host_valid,
    output nic_pkg::rx_word_t            host_word,
    output nic_pkg::drop_cnt_t           dropped_pkts
);
    import nic_pkg::*;

    // ------------------------------------------------------------
    // Local wires
    // ------------------------------------------------------------
    logic      wr_en;                               // Buffer write port
    buf_addr_t wr_addr;
    rx_word_t  wr_word;
    buf_addr_t rd_addr;                             // Buffer read port
    rx_word_t  rd_word;
    buf_ptr_t  commit_wr_ptr;                       // MAC side to reader
    buf_ptr_t  commit_rd_ptr;                       // Reader to MAC side

    // ------------------------------------------------------------
    // Instances
    // ------------------------------------------------------------
    rx_mac_interface rx_mac_interface_i (
        .clk156_25(clk156_25),                      // I
        .rst_n(rst_n),                              // I
        .rx_data(rx_data),                          // I [63:0]
        .rx_data_valid(rx_data_valid),              // I [7:0]
        .rx_good_frame(rx_good_frame),              // I
        .rx_bad_frame(rx_bad_frame),                // I
        .commit_rd_ptr(commit_rd_ptr),              // I [10:0]
        .wr_en(wr_en),                              // O
        .wr_addr(wr_addr),                          // O [9:0]
        .wr_word(wr_word),                          // O [72:0]
        .commit_wr_ptr(commit_wr_ptr),              // O [10:0]
        .dropped_pkts(dropped_pkts)                 // O [15:0]
    );

    rx_frame_buffer rx_frame_buffer_i (
        .clk156_25(clk156_25),                      // I
        .wr_en(wr_en),                              // I
        .wr_addr(wr_addr),                          // I [9:0]
        .wr_word(wr_word),                          // I [72:0]
        .rd_addr(rd_addr),                          // I [9:0]
        .rd_word(rd_word)                           // O [72:0]
    );

    rx_host_reader rx_host_reader_i (
        .clk156_25(clk156_25),                      // I
        .rst_n(rst_n),                              // I
        .host_rd_en(host_rd_en),                    // I
        .commit_wr_ptr(commit_wr_ptr),              // I [10:0]
        .rd_word(rd_word),                          // I [72:0]
        .rd_addr(rd_addr),                          // O [9:0]
        .commit_rd_ptr(commit_rd_ptr),              // O [10:0]
        .host_valid(host_valid),                    // O
        .host_word(host_word)                       // O [72:0]
    );

endmodule

//--- rx_frame_buffer.sv
// Receive frame buffer
// Simple dual-port word store between the MAC side and the host
// reader; one write port and one registered read port

`timescale 1ns/10ps

module rx_frame_buffer (
    input  logic                clk156_25,
    input  logic                wr_en,
    input  nic_pkg::buf_addr_t  wr_addr,
    input  nic_pkg::rx_word_t   wr_word,
    input  nic_pkg::buf_addr_t  rd_addr,
    output nic_pkg::rx_word_t   rd_word
);
    import nic_pkg::*;

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    rx_word_t mem [BUF_DEPTH];                      // Data, keep and last per slot

    // Write port
    always_ff @(posedge clk156_25) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // Read port, data one cycle after the address
    // The reader only addresses committed slots, so no
    // read and write ever target the same slot together
    always_ff @(posedge clk156_25) begin
        rd_word <= mem[rd_addr];
    end

endmodule

//--- rx_host_reader.sv
// Receive host reader
// Drains committed words from the frame buffer towards the host
// while the host allows it; valid lines up with the RAM output

`timescale 1ns/10ps

module rx_host_reader (
    input  logic                clk156_25,
    input  logic                rst_n,
    input  logic                host_rd_en,         // Host level, low holds data
    input  nic_pkg::buf_ptr_t   commit_wr_ptr,      // End of committed frames
    input  nic_pkg::rx_word_t   rd_word,            // Registered RAM data
    output nic_pkg::buf_addr_t  rd_addr,
    output nic_pkg::buf_ptr_t   commit_rd_ptr,      // Frees slots for the MAC side
    output logic                host_valid,
    output nic_pkg::rx_word_t   host_word
);
    import nic_pkg::*;

    // ------------------------------------------------------------
    // Read pointer
    // ------------------------------------------------------------
    buf_ptr_t rd_ptr;                               // Next slot to read
    logic     rd_issue;                             // One read this cycle

    // Committed data pending and host willing
    assign rd_issue = host_rd_en && (rd_ptr != commit_wr_ptr);

    assign rd_addr       = rd_ptr[BUF_AW-1:0];      // Drop wrap bit for RAM
    assign commit_rd_ptr = rd_ptr;                  // Slot freed once addressed

    always_ff @(posedge clk156_25) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            host_valid <= 1'b0;
        end else begin
            host_valid <= rd_issue;                 // Matches RAM read latency
            if (rd_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Host side
    // ------------------------------------------------------------
    // RAM output is already registered, qualified by host_valid
    assign host_word = rd_word;

endmodule

//--- rx_mac_interface.sv
// Receive MAC interface
// Stores incoming XGMAC words into the frame buffer one word late,
// tags the final word on a good frame and then commits the frame.
// Bad frames are rewound; frames that run out of room are rewound
// and counted as dropped.

`timescale 1ns/10ps

module rx_mac_interface (
    input  logic                         clk156_25,
    input  logic                         rst_n,
    input  logic [nic_pkg::DATA_W-1:0]   rx_data,
    input  logic [nic_pkg::KEEP_W-1:0]   rx_data_valid,
    input  logic                         rx_good_frame,
    input  logic                         rx_bad_frame,
    input  nic_pkg::buf_ptr_t            commit_rd_ptr,    // From host reader
    output logic                         wr_en,
    output nic_pkg::buf_addr_t           wr_addr,
    output nic_pkg::rx_word_t            wr_word,
    output nic_pkg::buf_ptr_t            commit_wr_ptr,    // To host reader
    output nic_pkg::drop_cnt_t           dropped_pkts
);
    import nic_pkg::*;

    // ------------------------------------------------------------
    // State
    // ------------------------------------------------------------
    logic [DATA_W-1:0] held_data;                   // Word waiting for its successor
    logic [KEEP_W-1:0] held_keep;
    logic              held_valid;                  // Held register occupied
    buf_ptr_t          wr_ptr;                      // Next free slot, uncommitted
    logic              overflow;                    // Current frame ran out of room
    logic              commit_pend;                 // Final word goes to RAM this cycle

    // Decode
    logic              word_in;
    logic              frame_end;
    buf_ptr_t          fill_level;
    logic              buf_full;
    logic              do_push;
    logic              do_last;
    logic              do_write;
    logic              ovf_hit;
    logic              drop_now;

    assign word_in    = |rx_data_valid;             // Any byte valid means a word
    assign frame_end  = rx_good_frame | rx_bad_frame;
    assign fill_level = wr_ptr - commit_rd_ptr;     // Includes uncommitted words
    assign buf_full   = (fill_level == buf_ptr_t'(BUF_DEPTH));

    // Mid-frame word pushes the previous one out
    assign do_push  = word_in & ~frame_end & held_valid & ~overflow & ~buf_full;
    // Good strobe flushes the held word as last
    assign do_last  = rx_good_frame & held_valid & ~overflow & ~buf_full;
    assign do_write = do_push | do_last;
    // Held word finds no slot and the rest of the frame is ignored
    assign ovf_hit  = word_in & ~frame_end & held_valid & ~overflow & buf_full;
    // Counted whichever strobe ends a frame that ran out of room
    assign drop_now = frame_end & (overflow | (held_valid & buf_full));

    // ------------------------------------------------------------
    // Payload path
    // ------------------------------------------------------------
    always_ff @(posedge clk156_25) begin
        if (word_in && !frame_end) begin
            held_data <= rx_data;                   // Capture newest word
            held_keep <= rx_data_valid;
        end
        if (do_write) begin
            wr_addr      <= wr_ptr[BUF_AW-1:0];     // Slot for the held word
            wr_word.data <= held_data;
            wr_word.keep <= held_keep;
            wr_word.last <= do_last;                // Only the strobe flush is last
        end
    end

    // ------------------------------------------------------------
    // Pointers, overflow and drop count
    // ------------------------------------------------------------
    always_ff @(posedge clk156_25) begin
        if (!rst_n) begin
            wr_en         <= 1'b0;
            commit_pend   <= 1'b0;
            held_valid    <= 1'b0;
            overflow      <= 1'b0;
            wr_ptr        <= '0;
            commit_wr_ptr <= '0;
            dropped_pkts  <= '0;
        end else begin
            wr_en       <= do_write;                // RAM write one cycle later
            commit_pend <= do_last;

            // Publish the frame once its last word is in RAM
            if (commit_pend) begin
                commit_wr_ptr <= wr_ptr;
            end

            if (frame_end) begin
                held_valid <= 1'b0;                 // Frame closed
                overflow   <= 1'b0;
                if (do_last) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end else begin
                    wr_ptr <= commit_wr_ptr;        // Rewind bad or dropped frame
                end
                if (drop_now) begin
                    dropped_pkts <= dropped_pkts + 1'b1;
                end
            end else if (word_in) begin
                held_valid <= 1'b1;
                if (do_push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (ovf_hit) begin
                    overflow <= 1'b1;               // Sticky until the strobe
                end
            end
        end
    end

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset generator
// 8 ns clock, synchronous active-low reset held for 16 cycles

`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD = 4;                 // 8 ns period
    localparam int RST_CYCLES  = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;                               // Held low from time zero
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                              // Released on an edge
    end

endmodule

//--- tb_nic_rx.sv
// Testbench for the NIC receive path
// Random MAC frames go in, host words come out and are compared
// against a queue model; drops are tracked during overflow

`timescale 1ns/10ps

module tb_nic_rx;
    import nic_pkg::*;

    // ------------------------------------------------------------
    // Test sizes
    // ------------------------------------------------------------
    localparam int MAX_LEN     = 40;                // Longest frame in words
    localparam int N_GOOD      = 30;                // Good frames, reader on
    localparam int N_MIXED     = 30;                // Good and bad mixed
    localparam int N_OVF       = 60;                // Reader off, 20..40 words each
    localparam int N_THROTTLE  = 20;                // At most 800 words outstanding
    localparam int N_FRAMES    = N_GOOD + N_MIXED + N_OVF + N_THROTTLE;
    localparam int WDOG_CYCLES = N_FRAMES * MAX_LEN * 4 + 4000;
    localparam int DRAIN_LIMIT = 8 * BUF_DEPTH;

    logic              clk;
    logic              rst_n;
    logic [DATA_W-1:0] rx_data;
    logic [KEEP_W-1:0] rx_data_valid;
    logic              rx_good_frame;
    logic              rx_bad_frame;
    logic              host_rd_en;
    logic              host_valid;
    rx_word_t          host_word;
    drop_cnt_t         dropped_pkts;

    // Model state
    rx_word_t  exp_q[$];                            // Words the host should see
    rx_word_t  frame_q[$];                          // Frame being sent
    drop_cnt_t exp_drops    = '0;
    int        stored_words = 0;                    // Committed, unread words
    logic      throttle     = 1'b0;                 // Random host_rd_en
    int        word_errs    = 0;
    int        drop_errs    = 0;
    int        flag_errs    = 0;
    int        other_errs   = 0;

    tb_clock_gen clock_gen_i (
        .clk(clk),
        .rst_n(rst_n)
    );

    nic_rx_top dut_i (
        .clk156_25(clk),
        .rst_n(rst_n),
        .rx_data(rx_data),
        .rx_data_valid(rx_data_valid),
        .rx_good_frame(rx_good_frame),
        .rx_bad_frame(rx_bad_frame),
        .host_rd_en(host_rd_en),
        .host_valid(host_valid),
        .host_word(host_word),
        .dropped_pkts(dropped_pkts)
    );

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_word(input string name, input rx_word_t got, input rx_word_t exp);
        if (got !== exp) begin
            $display("error: t=%0t %s got %h exp %h", $time, name, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_drops(input drop_cnt_t got, input drop_cnt_t exp);
        if (got !== exp) begin
            $display("error: t=%0t dropped_pkts got %0d exp %0d", $time, got, exp);
            drop_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: t=%0t %s got %b exp %b", $time, name, got, exp);
            flag_errs++;
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        if (throttle) begin
            host_rd_en <= 1'($urandom_range(1));    // Host pauses at random
        end
    endtask

    // Expected outcome of the frame in frame_q
    task automatic model_frame(input logic good, input logic track_room);
        int len;
        int free_slots;
        len        = frame_q.size();
        free_slots = BUF_DEPTH - stored_words;
        if (good && (!track_room || len <= free_slots)) begin
            foreach (frame_q[i]) begin
                exp_q.push_back(frame_q[i]);
            end
            stored_words += len;
        end else if (track_room && len > free_slots) begin
            exp_drops = exp_drops + 1'b1;           // Too long, either strobe
        end
    endtask

    task automatic send_frame(input int len, input logic good, input logic track_room);
        rx_word_t          w;
        logic [KEEP_W-1:0] keep;
        int                gap;
        frame_q.delete();
        for (int i = 0; i < len; i++) begin
            gap = ($urandom_range(3) == 0) ? int'($urandom_range(2, 1)) : 0;
            repeat (gap) begin
                next_cycle();
                rx_data_valid <= '0;                // Idle inside the frame
            end
            keep = '1;
            if (i == len - 1) begin
                keep = keep >> $urandom_range(KEEP_W - 1);  // Partial tail
            end
            w.data = {$urandom, $urandom};
            w.keep = keep;
            w.last = (i == len - 1);
            next_cycle();
            rx_data       <= w.data;
            rx_data_valid <= w.keep;
            frame_q.push_back(w);
        end
        model_frame(good, track_room);
        gap = int'($urandom_range(2));
        repeat (gap) begin
            next_cycle();
            rx_data_valid <= '0;
        end
        next_cycle();
        rx_data_valid <= '0;
        rx_good_frame <= good;                      // One-cycle strobe
        rx_bad_frame  <= !good;
        next_cycle();
        rx_good_frame <= 1'b0;
        rx_bad_frame  <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("output stalled at %0t with %0d words still expected",
                     $time, exp_q.size());
            other_errs++;
            exp_q.delete();
        end
        repeat (8) next_cycle();                    // Room for stray words
        stored_words = 0;
    endtask

    // ------------------------------------------------------------
    // Output monitor on the falling edge
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && host_valid) begin
            if (exp_q.size() == 0) begin
                $display("host delivered word %h at %0t with no frame waiting for it",
                         host_word, $time);
                other_errs++;
            end else begin
                check_word("host_word", host_word, exp_q.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the test did not finish", WDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        drop_cnt_t drops_before;
        void'($urandom(25323));
        rx_data       <= '0;
        rx_data_valid <= '0;
        rx_good_frame <= 1'b0;
        rx_bad_frame  <= 1'b0;
        host_rd_en    <= 1'b0;

        // Idle state right after reset
        @(posedge rst_n);
        @(negedge clk);
        check_flag("host_valid", host_valid, 1'b0);
        check_drops(dropped_pkts, '0);

        // Good frames with the reader on
        next_cycle();
        host_rd_en <= 1'b1;
        for (int f = 0; f < N_GOOD; f++) begin
            send_frame(int'($urandom_range(MAX_LEN, 1)), 1'b1, 1'b0);
        end
        wait_drain();
        check_drops(dropped_pkts, exp_drops);

        // Bad frames mixed in and never seen or counted
        for (int f = 0; f < N_MIXED; f++) begin
            send_frame(int'($urandom_range(MAX_LEN, 1)), $urandom_range(3) != 0, 1'b0);
        end
        wait_drain();
        check_drops(dropped_pkts, exp_drops);

        // Overflow with the host holding off
        host_rd_en <= 1'b0;
        repeat (4) next_cycle();
        drops_before = exp_drops;
        for (int f = 0; f < N_OVF; f++) begin
            send_frame(int'($urandom_range(MAX_LEN, 20)), $urandom_range(3) != 0, 1'b1);
        end
        repeat (4) next_cycle();
        check_drops(dropped_pkts, exp_drops);
        if (exp_drops == drops_before) begin
            $display("overflow phase dropped no frame, buffer never filled");
            other_errs++;
        end
        host_rd_en <= 1'b1;                         // Release the stored frames
        wait_drain();
        check_drops(dropped_pkts, exp_drops);

        // Random host pauses well below the buffer size
        throttle = 1'b1;
        for (int f = 0; f < N_THROTTLE; f++) begin
            send_frame(int'($urandom_range(MAX_LEN, 1)), 1'b1, 1'b0);
        end
        wait_drain();
        throttle = 1'b0;
        check_drops(dropped_pkts, exp_drops);

        $display("errors: word=%0d drops=%0d flag=%0d other=%0d",
                 word_errs, drop_errs, flag_errs, other_errs);
        if (word_errs + drop_errs + flag_errs + other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
